//--- common/dma_adapter_params.svh
/* burst geometry and membridge register map; one command moves 16 words of 64 bits
   register addresses and setup values match the membridge register file */
`ifndef DMA_ADAPTER_PARAMS_SVH
`define DMA_ADAPTER_PARAMS_SVH

`define DMA_BURST_WORDS  16
`define DMA_WORD_W       64
`define DMA_CNT_W        5

`define MEMBR_REG_CTRL   16'h200
`define MEMBR_REG_LOADDR 16'h202
`define MEMBR_REG_SIZE   16'h203
`define MEMBR_REG_START  16'h204
`define MEMBR_REG_LEN    16'h205
`define MEMBR_REG_WIDTH  16'h206
`define MEMBR_REG_MODE   16'h207

`define MEMBR_MODE_VAL   32'h3
`define MEMBR_BURST_VAL  32'h10
`define MEMBR_START_VAL  32'h0
`define MEMBR_CTRL_VAL   32'h3

`endif

//--- common/dma_adapter_pkg.sv
/* types shared by the adapter blocks; the burst address holds address bits 31:7 only */
`include "dma_adapter_params.svh"

package dma_adapter_pkg;

    typedef logic [`DMA_WORD_W-1:0] word_t;

    typedef logic [24:0] burst_addr_t;  // byte address bits 31:7

    typedef struct packed {
        logic        is_write;  // 1 = write into membridge
        burst_addr_t addr;
    } dma_cmd_t;

    // one membridge register write, sent as six bytes
    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] data;
    } reg_write_t;

endpackage

//--- design/dma_cmd_ctrl.sv
/* one command in flight; cmd_val while busy is dropped, not queued */
module dma_cmd_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cmd_val,
    input  dma_adapter_pkg::dma_cmd_t cmd,
    input  logic                      wr_done,
    input  logic                      rd_done,
    output logic                      cmd_busy,
    output logic                      wr_start,
    output logic                      rd_start,
    output logic                      cmd_wrmem,
    output dma_adapter_pkg::dma_cmd_t cmd_lat
);
    logic accept;
    logic start_q;  // start pulse lines up with the latched command

    assign accept    = cmd_val & ~cmd_busy;
    assign wr_start  = start_q & cmd_lat.is_write;
    assign rd_start  = start_q & ~cmd_lat.is_write;
    assign cmd_wrmem = ~cmd_lat.is_write;  // membridge reads memory on a dma write

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cmd_busy <= 1'b0;
            start_q  <= 1'b0;
            cmd_lat  <= '0;
        end
        else
        begin
            start_q <= accept;
            if (accept)
            begin
                cmd_busy <= 1'b1;
                cmd_lat  <= cmd;
            end
            else if (wr_done | rd_done)
                cmd_busy <= 1'b0;
        end
    end

    // a path only reports done for the command in flight
    a_done_in_busy: assert property (@(posedge clk) disable iff (rst)
        (wr_done || rd_done) |-> cmd_busy);

endmodule

//--- design/burst_write.sv
/* takes exactly DMA_BURST_WORDS words per start; done also waits for the register setup
   to finish, in whichever order the two arrive */
`include "dma_adapter_params.svh"

module burst_write (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   seq_done,
    input  logic                   wr_val_in,
    input  dma_adapter_pkg::word_t wr_data_in,
    output logic                   wr_ack,
    output logic                   buf_wr,
    output dma_adapter_pkg::word_t buf_wdata,
    output logic                   buf_wpage_nxt,
    output logic                   page_ready_chn,
    output logic                   xfer_reset_page_rd,
    output logic                   done
);
    typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_WAIT_SETUP} state_t;

    localparam logic [`DMA_CNT_W-1:0] LAST_WORD = `DMA_BURST_WORDS - 1;

    state_t                state;
    logic [`DMA_CNT_W-1:0] cnt;         // words accepted so far
    logic                  setup_seen;  // seq_done arrived during the data phase
    logic                  page_nxt;
    logic                  last_word;
    logic                  setup_ok;

    assign wr_ack         = (state == ST_DATA) & wr_val_in;
    assign last_word      = wr_ack & (cnt == LAST_WORD);
    assign setup_ok       = setup_seen | seq_done;
    assign buf_wpage_nxt  = page_nxt;
    assign page_ready_chn = page_nxt;  // page is full once the last word is written

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state              <= ST_IDLE;
            cnt                <= '0;
            setup_seen         <= 1'b0;
            buf_wr             <= 1'b0;
            page_nxt           <= 1'b0;
            xfer_reset_page_rd <= 1'b0;
            done               <= 1'b0;
        end
        else
        begin
            buf_wr             <= wr_ack;
            page_nxt           <= last_word;
            xfer_reset_page_rd <= 1'b0;
            done               <= 1'b0;
            case (state)
                ST_IDLE:
                    if (start)
                    begin
                        state              <= ST_DATA;
                        cnt                <= '0;
                        setup_seen         <= 1'b0;
                        xfer_reset_page_rd <= 1'b1;
                    end
                ST_DATA:
                begin
                    setup_seen <= setup_ok;
                    if (wr_ack)
                        cnt <= cnt + 1'b1;
                    if (last_word)
                    begin
                        state <= setup_ok ? ST_IDLE : ST_WAIT_SETUP;
                        done  <= setup_ok;
                    end
                end
                default:  // all words in, address still going out
                    if (seq_done)
                    begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_ack)
            buf_wdata <= wr_data_in;
    end

    // a new start never lands on a write still in progress
    a_start_in_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> state == ST_IDLE);

endmodule

//--- design/burst_read.sv
/* data phase opens only after both the setup sequence and the bridge's rdata_done;
   rd_data_out is the raw buffer output, valid with rd_val_out */
`include "dma_adapter_params.svh"

module burst_read (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   seq_done,
    input  logic                   rdata_done,
    input  logic                   rd_ack_in,
    input  dma_adapter_pkg::word_t buf_rdata,
    output logic                   rd_val_out,
    output dma_adapter_pkg::word_t rd_data_out,
    output logic                   buf_rd,
    output logic                   buf_rpage_nxt,
    output logic                   done
);
    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_DATA} state_t;

    localparam logic [`DMA_CNT_W-1:0] LAST_ACK = `DMA_BURST_WORDS - 1;

    state_t                state;
    logic [`DMA_CNT_W-1:0] cnt;
    logic                  setup_seen;  // sticky seq_done
    logic                  data_seen;   // sticky rdata_done
    logic                  last_ack;

    assign last_ack      = (state == ST_DATA) & rd_ack_in & (cnt == LAST_ACK);
    assign rd_val_out    = buf_rd;
    assign rd_data_out   = buf_rdata;
    assign buf_rpage_nxt = done;  // page released with the last word

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= ST_IDLE;
            cnt        <= '0;
            setup_seen <= 1'b0;
            data_seen  <= 1'b0;
            buf_rd     <= 1'b0;
            done       <= 1'b0;
        end
        else
        begin
            buf_rd <= (state == ST_DATA) & rd_ack_in;
            done   <= last_ack;
            case (state)
                ST_IDLE:
                    if (start)
                    begin
                        state      <= ST_WAIT;
                        cnt        <= '0;
                        setup_seen <= 1'b0;
                        data_seen  <= 1'b0;
                    end
                ST_WAIT:
                begin
                    setup_seen <= setup_seen | seq_done;
                    data_seen  <= data_seen | rdata_done;
                    if ((setup_seen | seq_done) & (data_seen | rdata_done))
                        state <= ST_DATA;
                end
                default:
                begin
                    if (rd_ack_in)
                        cnt <= cnt + 1'b1;
                    if (last_ack)
                        state <= ST_IDLE;
                end
            endcase
        end
    end

    // the bridge handshake always costs at least one cycle
    a_no_instant_done: assert property (@(posedge clk) disable iff (rst)
        start |=> !done);

endmodule

//--- membridge/membr_setup_seq.sv
/* full register setup on the first start after reset, low address and control after that;
   start is ignored while a sequence runs */
`include "dma_adapter_params.svh"

module membr_setup_seq (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  dma_adapter_pkg::burst_addr_t addr,
    input  logic                         ser_busy,
    output logic                         reg_wr_stb,
    output dma_adapter_pkg::reg_write_t  reg_wr,
    output logic                         seq_done
);
    import dma_adapter_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE, S_MODE, S_WIDTH, S_LEN, S_START, S_SIZE, S_LOADDR, S_CTRL, S_FINISH
    } state_t;

    state_t     state;
    state_t     next_reg;
    reg_write_t cur_reg;
    logic       init_done;  // bridge already set up, cleared only by reset
    logic       ser_free;
    logic       issue;

    // the strobe cycle itself is not yet seen as busy
    assign ser_free = ~ser_busy & ~reg_wr_stb;
    assign issue    = ser_free & (state != S_IDLE) & (state != S_FINISH);

    always_comb
    begin
        cur_reg  = '0;
        next_reg = S_IDLE;
        case (state)
            S_MODE:
            begin
                cur_reg  = {`MEMBR_REG_MODE, `MEMBR_MODE_VAL};
                next_reg = S_WIDTH;
            end
            S_WIDTH:
            begin
                cur_reg  = {`MEMBR_REG_WIDTH, `MEMBR_BURST_VAL};
                next_reg = S_LEN;
            end
            S_LEN:
            begin
                cur_reg  = {`MEMBR_REG_LEN, `MEMBR_BURST_VAL};
                next_reg = S_START;
            end
            S_START:
            begin
                cur_reg  = {`MEMBR_REG_START, `MEMBR_START_VAL};
                next_reg = S_SIZE;
            end
            S_SIZE:
            begin
                cur_reg  = {`MEMBR_REG_SIZE, `MEMBR_BURST_VAL};
                next_reg = S_LOADDR;
            end
            S_LOADDR:
            begin
                cur_reg  = {`MEMBR_REG_LOADDR, 7'h0, addr};  // burst address, zero-extended
                next_reg = S_CTRL;
            end
            S_CTRL:
            begin
                cur_reg  = {`MEMBR_REG_CTRL, `MEMBR_CTRL_VAL};
                next_reg = S_FINISH;
            end
            default:
                next_reg = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= S_IDLE;
            init_done  <= 1'b0;
            reg_wr_stb <= 1'b0;
            seq_done   <= 1'b0;
        end
        else
        begin
            reg_wr_stb <= issue;
            seq_done   <= 1'b0;
            case (state)
                S_IDLE:
                    if (start)
                    begin
                        state     <= init_done ? S_LOADDR : S_MODE;
                        init_done <= 1'b1;
                    end
                S_FINISH:
                    if (ser_free)  // control write fully shifted out
                    begin
                        state    <= S_IDLE;
                        seq_done <= 1'b1;
                    end
                default:
                    if (issue)
                        state <= next_reg;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
            reg_wr <= cur_reg;
    end

    // never hand the serializer a write while it is still shifting
    a_stb_ser_idle: assert property (@(posedge clk) disable iff (rst)
        reg_wr_stb |-> !ser_busy);

endmodule

//--- membridge/reg_serializer.sv
/* one register write at a time, a strobe while busy is lost; bytes go out as
   address low, address high, data bytes 0 to 3, cmd_ad is zero between writes */
module reg_serializer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        reg_wr_stb,
    input  dma_adapter_pkg::reg_write_t reg_wr,
    output logic                        ser_busy,
    output logic [7:0]                  cmd_ad,
    output logic                        cmd_stb
);
    localparam logic [2:0] LAST_BYTE = 3'd5;

    logic [47:0] shift;  // next byte at the low end
    logic [2:0]  byte_cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ser_busy <= 1'b0;
            byte_cnt <= '0;
            cmd_ad   <= '0;
            cmd_stb  <= 1'b0;
        end
        else
        begin
            cmd_stb <= ser_busy & (byte_cnt == 3'd0);  // marks the address low byte
            cmd_ad  <= ser_busy ? shift[7:0] : 8'h0;
            if (ser_busy)
            begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == LAST_BYTE)
                    ser_busy <= 1'b0;
            end
            else if (reg_wr_stb)
            begin
                ser_busy <= 1'b1;
                byte_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (~ser_busy & reg_wr_stb)
            shift <= {reg_wr.data, reg_wr.addr};
        else if (ser_busy)
            shift <= shift >> 8;
    end

endmodule

//--- design/dma_adapter.sv
/* single-burst adapter between the dma buffer and the membridge register port;
   one command at a time, cmd_busy falls when it has completed */
module dma_adapter (
    input  logic                      clk,
    input  logic                      rst,
    // command
    input  logic                      cmd_val,
    input  dma_adapter_pkg::dma_cmd_t cmd,
    output logic                      cmd_busy,
    // dma data stream
    input  dma_adapter_pkg::word_t    wr_data_in,
    input  logic                      wr_val_in,
    output logic                      wr_ack,
    output dma_adapter_pkg::word_t    rd_data_out,
    output logic                      rd_val_out,
    input  logic                      rd_ack_in,
    // membridge
    output logic [7:0]                cmd_ad,
    output logic                      cmd_stb,
    output logic                      cmd_wrmem,
    output logic                      page_ready_chn,
    output logic                      xfer_reset_page_rd,
    output logic                      buf_wpage_nxt,
    output logic                      buf_wr,
    output dma_adapter_pkg::word_t    buf_wdata,
    output logic                      buf_rpage_nxt,
    output logic                      buf_rd,
    input  dma_adapter_pkg::word_t    buf_rdata,
    input  logic                      rdata_done
);
    import dma_adapter_pkg::*;

    dma_cmd_t   cmd_lat;
    reg_write_t reg_wr;
    logic       wr_start;
    logic       rd_start;
    logic       wr_done;
    logic       rd_done;
    logic       seq_done;
    logic       reg_wr_stb;
    logic       ser_busy;

    dma_cmd_ctrl u_cmd_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cmd_val   (cmd_val),
        .cmd       (cmd),
        .wr_done   (wr_done),
        .rd_done   (rd_done),
        .cmd_busy  (cmd_busy),
        .wr_start  (wr_start),
        .rd_start  (rd_start),
        .cmd_wrmem (cmd_wrmem),
        .cmd_lat   (cmd_lat)
    );

    burst_write u_burst_write (
        .clk                (clk),
        .rst                (rst),
        .start              (wr_start),
        .seq_done           (seq_done),
        .wr_val_in          (wr_val_in),
        .wr_data_in         (wr_data_in),
        .wr_ack             (wr_ack),
        .buf_wr             (buf_wr),
        .buf_wdata          (buf_wdata),
        .buf_wpage_nxt      (buf_wpage_nxt),
        .page_ready_chn     (page_ready_chn),
        .xfer_reset_page_rd (xfer_reset_page_rd),
        .done               (wr_done)
    );

    burst_read u_burst_read (
        .clk           (clk),
        .rst           (rst),
        .start         (rd_start),
        .seq_done      (seq_done),
        .rdata_done    (rdata_done),
        .rd_ack_in     (rd_ack_in),
        .buf_rdata     (buf_rdata),
        .rd_val_out    (rd_val_out),
        .rd_data_out   (rd_data_out),
        .buf_rd        (buf_rd),
        .buf_rpage_nxt (buf_rpage_nxt),
        .done          (rd_done)
    );

    // bridge setup runs alongside either data path
    membr_setup_seq u_setup_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (wr_start | rd_start),
        .addr       (cmd_lat.addr),
        .ser_busy   (ser_busy),
        .reg_wr_stb (reg_wr_stb),
        .reg_wr     (reg_wr),
        .seq_done   (seq_done)
    );

    reg_serializer u_reg_ser (
        .clk        (clk),
        .rst        (rst),
        .reg_wr_stb (reg_wr_stb),
        .reg_wr     (reg_wr),
        .ser_busy   (ser_busy),
        .cmd_ad     (cmd_ad),
        .cmd_stb    (cmd_stb)
    );

endmodule

//--- verification/membridge_model.sv
/* behavioural membridge; logs decoded register writes and buffer words, holds one read page
   rdata_done follows a read's control write after a fixed delay */
`include "dma_adapter_params.svh"

module membridge_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             cmd_ad,
    input  logic                   cmd_stb,
    input  logic                   cmd_wrmem,
    input  logic                   buf_wr,
    input  dma_adapter_pkg::word_t buf_wdata,
    input  logic                   buf_rd,
    output dma_adapter_pkg::word_t buf_rdata,
    output logic                   rdata_done
);
    timeunit 1ns;
    timeprecision 1ns;
    import dma_adapter_pkg::*;

    localparam int RDATA_DELAY = 4;

    reg_write_t  reg_log [0:63];
    int          reg_cnt;
    word_t       wbuf [0:127];
    int          wcnt;
    word_t       rd_mem [0:15];  // loaded by the testbench
    logic [3:0]  rd_ptr;
    logic [47:0] bytes;          // address low byte at the bottom
    int          byte_idx;
    int          delay_cnt;

    assign buf_rdata = rd_mem[rd_ptr];

    always @(posedge clk)
    begin
        logic [47:0] full;
        full = bytes;
        full[8*byte_idx +: 8] = cmd_ad;
        if (rst)
        begin
            reg_cnt    <= 0;
            byte_idx   <= 0;
            delay_cnt  <= 0;
            rdata_done <= 1'b0;
        end
        else
        begin
            rdata_done <= (delay_cnt == 1);
            if (delay_cnt > 0)
                delay_cnt <= delay_cnt - 1;
            if (cmd_stb)
            begin
                bytes    <= {40'h0, cmd_ad};
                byte_idx <= 1;
            end
            else if (byte_idx > 0)
            begin
                bytes <= full;
                if (byte_idx == 5)
                begin
                    reg_log[reg_cnt[5:0]] <= {full[15:0], full[47:16]};
                    reg_cnt               <= reg_cnt + 1;
                    byte_idx              <= 0;
                    if (full[15:0] == `MEMBR_REG_CTRL && cmd_wrmem)
                        delay_cnt <= RDATA_DELAY;  // read: page fetch starts now
                end
                else
                    byte_idx <= byte_idx + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        if (rst)
            wcnt <= 0;
        else if (buf_wr)
        begin
            wbuf[wcnt[6:0]] <= buf_wdata;
            wcnt            <= wcnt + 1;
        end
    end

    always @(posedge clk)
    begin
        if (rst || rdata_done)
            rd_ptr <= '0;  // fresh page
        else if (buf_rd)
            rd_ptr <= rd_ptr + 1'b1;
    end

endmodule

//--- verification/tb_dma_adapter.sv
/* directed tests of the dma adapter against the behavioural membridge
   inputs change on the falling edge, registered outputs are sampled there */
`include "dma_adapter_params.svh"

module tb_dma_adapter;
    timeunit 1ns;
    timeprecision 1ns;
    import dma_adapter_pkg::*;

    localparam int MAX_CYCLES = 4000;  // each test needs under 200 cycles

    logic       clk = 1'b0;
    logic       rst;
    logic       cmd_val;
    dma_cmd_t   cmd;
    logic       cmd_busy;
    word_t      wr_data_in;
    logic       wr_val_in;
    logic       wr_ack;
    word_t      rd_data_out;
    logic       rd_val_out;
    logic       rd_ack_in;
    logic [7:0] cmd_ad;
    logic       cmd_stb;
    logic       cmd_wrmem;
    logic       page_ready_chn;
    logic       xfer_reset_page_rd;
    logic       buf_wpage_nxt;
    logic       buf_wr;
    word_t      buf_wdata;
    logic       buf_rpage_nxt;
    logic       buf_rd;
    word_t      buf_rdata;
    logic       rdata_done;

    integer seed;
    int     value_errs = 0;
    int     other_errs = 0;
    int     cycles = 0;
    int     pready_cnt = 0;
    int     wpage_cnt = 0;
    int     rpage_cnt = 0;
    int     xreset_cnt = 0;
    word_t  words [0:`DMA_BURST_WORDS-1];

    dma_adapter dut_i (.*);
    membridge_model model_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run still going after %0d cycles, a handshake never came",
                     MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(negedge clk)
    begin
        if (page_ready_chn)
            pready_cnt++;
        if (buf_wpage_nxt)
            wpage_cnt++;
        if (buf_rpage_nxt)
            rpage_cnt++;
        if (xfer_reset_page_rd)
            xreset_cnt++;
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            value_errs++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_write_t exp, input reg_write_t act);
        if (exp !== act)
        begin
            value_errs++;
            $display("[FAIL] %s: expected %h/%h, actual %h/%h",
                     name, exp.addr, exp.data, act.addr, act.data);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            value_errs++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic count_equal(input string what, input int exp, input int act);
        if (exp != act)
        begin
            other_errs++;
            $display("%s: counted %0d, expected %0d", what, act, exp);
        end
    endtask

    // full setup order; entries 5 and 6 alone for every later command
    function automatic reg_write_t expected_reg(input int n, input burst_addr_t addr);
        case (n)
            0:       return {`MEMBR_REG_MODE, `MEMBR_MODE_VAL};
            1:       return {`MEMBR_REG_WIDTH, `MEMBR_BURST_VAL};
            2:       return {`MEMBR_REG_LEN, `MEMBR_BURST_VAL};
            3:       return {`MEMBR_REG_START, `MEMBR_START_VAL};
            4:       return {`MEMBR_REG_SIZE, `MEMBR_BURST_VAL};
            5:       return {`MEMBR_REG_LOADDR, 7'h0, addr};
            default: return {`MEMBR_REG_CTRL, `MEMBR_CTRL_VAL};
        endcase
    endfunction

    task automatic check_regs(input string name, input int base, input bit full,
                              input burst_addr_t addr);
        int n;
        int i;
        n = full ? 7 : 2;
        count_equal({name, " register writes"}, n, model_i.reg_cnt - base);
        for (i = 0; i < n && base + i < model_i.reg_cnt; i++)
            check_reg(name, expected_reg(7 - n + i, addr), model_i.reg_log[base + i]);
    endtask

    task automatic issue_cmd(input logic is_write, input burst_addr_t addr);
        @(negedge clk);
        cmd_val = 1'b1;
        cmd     = {is_write, addr};
        @(negedge clk);
        cmd_val = 1'b0;
    endtask

    task automatic wait_idle;
        while (cmd_busy)
            @(negedge clk);
    endtask

    task automatic feed_words(input bit gaps, input bit intrude, input burst_addr_t other);
        int idx;
        int k;
        idx = 0;
        k = 0;
        while (idx < `DMA_BURST_WORDS)
        begin
            wr_val_in  = !(gaps && (($random(seed) & 3) == 0));
            wr_data_in = words[idx];
            cmd_val    = intrude && (k < 4);  // a second command while busy
            cmd        = {1'b1, other};
            #1;
            if (wr_ack)
                idx++;
            k++;
            @(negedge clk);
        end
        wr_val_in = 1'b0;
        cmd_val   = 1'b0;
    endtask

    task automatic run_write(input string name, input burst_addr_t addr, input bit full,
                             input bit gaps, input bit intrude);
        int reg_base;
        int word_base;
        int pr_base;
        int wp_base;
        int xr_base;
        int i;
        reg_base  = model_i.reg_cnt;
        word_base = model_i.wcnt;
        pr_base   = pready_cnt;
        wp_base   = wpage_cnt;
        xr_base   = xreset_cnt;
        for (i = 0; i < `DMA_BURST_WORDS; i++)
            words[i] = {$random(seed), $random(seed)};
        issue_cmd(1'b1, addr);
        check_bit({name, " busy"}, 1'b1, cmd_busy);
        check_bit({name, " cmd_wrmem"}, 1'b0, cmd_wrmem);
        feed_words(gaps, intrude, ~addr);
        wait_idle();
        check_regs(name, reg_base, full, addr);
        count_equal({name, " buffer words"}, `DMA_BURST_WORDS, model_i.wcnt - word_base);
        for (i = 0; i < `DMA_BURST_WORDS; i++)
            check_word({name, " buffer"}, words[i], model_i.wbuf[word_base + i]);
        count_equal({name, " page_ready_chn pulses"}, 1, pready_cnt - pr_base);
        count_equal({name, " buf_wpage_nxt pulses"}, 1, wpage_cnt - wp_base);
        count_equal({name, " xfer_reset_page_rd pulses"}, 1, xreset_cnt - xr_base);
    endtask

    task automatic reset_values;
        check_bit("reset cmd_busy", 1'b0, cmd_busy);
        check_bit("reset cmd_stb", 1'b0, cmd_stb);
        check_bit("reset buf_wr", 1'b0, buf_wr);
        check_bit("reset buf_rd", 1'b0, buf_rd);
        check_bit("reset rd_val_out", 1'b0, rd_val_out);
        check_bit("reset wr_ack", 1'b0, wr_ack);
        check_bit("reset page_ready_chn", 1'b0, page_ready_chn);
        check_bit("reset buf_wpage_nxt", 1'b0, buf_wpage_nxt);
        check_bit("reset buf_rpage_nxt", 1'b0, buf_rpage_nxt);
        check_bit("reset xfer_reset_page_rd", 1'b0, xfer_reset_page_rd);
    endtask

    task automatic first_write;
        run_write("first write", 25'h0_1234, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic later_write;
        run_write("later write", 25'h1_5a5a, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic write_backpressure;
        run_write("write gaps", 25'h0_0f0f, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic busy_protect;
        run_write("busy protect", 25'h0_4321, 1'b0, 1'b0, 1'b1);
        repeat (16) @(negedge clk);
        check_bit("busy protect no restart", 1'b0, cmd_busy);
    endtask

    task automatic read_burst;
        int reg_base;
        int rp_base;
        int xr_base;
        int rcv;
        int i;
        for (i = 0; i < `DMA_BURST_WORDS; i++)
        begin
            words[i]          = {$random(seed), $random(seed)};
            model_i.rd_mem[i] = words[i];
        end
        reg_base = model_i.reg_cnt;
        rp_base  = rpage_cnt;
        xr_base  = xreset_cnt;
        issue_cmd(1'b0, 25'h0_7e01);
        check_bit("read cmd_wrmem", 1'b1, cmd_wrmem);
        rcv = 0;
        while (rcv < `DMA_BURST_WORDS)
        begin
            if (rd_val_out)
            begin
                check_word("read data", words[rcv], rd_data_out);
                rcv++;
            end
            rd_ack_in = ($random(seed) & 3) != 0;
            @(negedge clk);
        end
        rd_ack_in = 1'b0;
        wait_idle();
        check_regs("read", reg_base, 1'b0, 25'h0_7e01);
        count_equal("read buf_rpage_nxt pulses", 1, rpage_cnt - rp_base);
        count_equal("read xfer_reset_page_rd pulses", 0, xreset_cnt - xr_base);
    endtask

    initial
    begin
        seed       = 66188;
        rst        = 1'b1;
        cmd_val    = 1'b0;
        cmd        = '0;
        wr_val_in  = 1'b0;
        wr_data_in = '0;
        rd_ack_in  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_values();
        first_write();
        later_write();
        read_burst();
        write_backpressure();
        busy_protect();
        $display("summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+common
common/dma_adapter_pkg.sv
design/dma_cmd_ctrl.sv
design/burst_write.sv
design/burst_read.sv
membridge/membr_setup_seq.sv
membridge/reg_serializer.sv
design/dma_adapter.sv
verification/membridge_model.sv
verification/tb_dma_adapter.sv

//--- Makefile
# Verilator build and run of the dma adapter testbench
VERILATOR  ?= verilator
TOP        ?= tb_dma_adapter
RTL_TOP    ?= dma_adapter
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= common/dma_adapter_pkg.sv design/dma_cmd_ctrl.sv design/burst_write.sv \
              design/burst_read.sv membridge/membr_setup_seq.sv membridge/reg_serializer.sv \
              design/dma_adapter.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+common $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
